/* hw/exec_settings.svh */
// Execute stage settings
// Datapath widths and CSR address field positions
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

`default_nettype none

// Datapath widths
`define EXEC_XLEN         32
`define EXEC_REG_W        5
`define EXEC_CSR_ADDR_W   12

// CSR address fields of two bits each
// Both ones in the top field marks a read-only CSR
`define EXEC_CSR_RO_MSB   11
// Lowest privilege allowed to touch the CSR
`define EXEC_CSR_PRIV_MSB 9

`default_nettype wire

`endif

/* hw/exec_pkg.sv */
// Execute stage package
// Operation, CSR and privilege encodings plus the bundles passed between blocks
`include "exec_settings.svh"

`default_nettype none

package exec_pkg;

    // Decoded operations kept in this core
    typedef enum logic [5:0] {
        NOP, LUI, AUIPC, ADD, SUB, SLT, SLTU, XOR, OR, AND, SLL, SRL, SRA,
        JAL, JALR, BEQ, BNE, BLT, BLTU, BGE, BGEU,
        LB, LBU, LH, LHU, LW, SB, SH, SW,
        CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI,
        ECALL, EBREAK, MRET
    } exec_op_e;

    typedef enum logic [1:0] {
        NONE, WRITE, SET, CLEAR
    } csr_op_e;

    typedef enum logic [1:0] {
        USER    = 2'b00,
        MACHINE = 2'b11
    } priv_e;

    // mcause values of the causes this stage can raise
    typedef enum logic [3:0] {
        NE                  = 4'd0,
        ILLEGAL_INSTRUCTION = 4'd2,
        BREAKPOINT          = 4'd3,
        ECALL_FROM_UMODE    = 4'd8,
        ECALL_FROM_MMODE    = 4'd11
    } exc_code_e;

    ////////////////////////////////////////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        exec_op_e                      op;
        logic [`EXEC_XLEN-1:0]         pc;
        logic [`EXEC_XLEN-1:0]         rs1_data;
        logic [`EXEC_XLEN-1:0]         rs2_data;
        logic [`EXEC_XLEN-1:0]         second_operand;
        logic [`EXEC_REG_W-1:0]        rd;
        logic [`EXEC_REG_W-1:0]        rs1;
        logic                          compressed;
        logic [`EXEC_XLEN-1:0]         jump_imm_target;
        logic [`EXEC_CSR_ADDR_W-1:0]   csr_address;
    } exec_in_t;

    typedef struct packed {
        logic [`EXEC_XLEN-1:0]  result;
        logic [`EXEC_XLEN-1:0]  sum;
        logic                   equal;
        logic                   less_than;
        logic                   less_than_unsigned;
    } alu_out_t;

    typedef struct packed {
        logic [`EXEC_XLEN-1:0]  address;
        logic                   read_enable;
        logic [3:0]             write_enable;
        logic [`EXEC_XLEN-1:0]  write_data;
    } mem_req_t;

    typedef struct packed {
        logic                   read_enable;
        logic                   write_enable;
        csr_op_e                operation;
        logic [`EXEC_XLEN-1:0]  data;
    } csr_req_t;

    typedef struct packed {
        logic       raise_exception;
        logic       machine_return;
        logic       interrupt_ack;
        exc_code_e  exception_code;
    } trap_t;

    typedef struct packed {
        logic                    write_enable;
        exec_op_e                op;
        logic [`EXEC_XLEN-1:0]   result;
        logic [`EXEC_REG_W-1:0]  rd;
    } wb_t;

endpackage

`default_nettype wire

/* hw/exec_alu.sv */
// Execute stage ALU
// Arithmetic, logic, shift and compare results plus the flags used by branches
`timescale 1ns/1ps
`include "exec_settings.svh"

`default_nettype none

module exec_alu
    import exec_pkg::*;
(
    input  exec_in_t  in_i,
    output alu_out_t  alu_o
);

    logic [`EXEC_XLEN-1:0]  op_a;
    logic [`EXEC_XLEN-1:0]  op_b;
    logic [`EXEC_XLEN-1:0]  sum;
    logic [`EXEC_XLEN-1:0]  diff;
    logic [`EXEC_XLEN-1:0]  link;
    logic [`EXEC_XLEN-1:0]  result;
    logic [4:0]             shamt;
    logic                   equal;
    logic                   less_than;
    logic                   less_than_unsigned;

    assign op_a  = in_i.rs1_data;
    assign op_b  = in_i.second_operand;
    assign shamt = op_b[4:0];

    assign sum  = op_a + op_b;
    assign diff = op_a - op_b;

    // Return address for JAL and JALR
    assign link = in_i.pc + (in_i.compressed ? `EXEC_XLEN'd2 : `EXEC_XLEN'd4);

    assign equal              = (op_a == op_b);
    assign less_than          = ($signed(op_a) < $signed(op_b));
    assign less_than_unsigned = (op_a < op_b);

    always_comb begin
        unique case (in_i.op)
            SUB:       result = diff;
            SLT:       result = {{(`EXEC_XLEN-1){1'b0}}, less_than};
            SLTU:      result = {{(`EXEC_XLEN-1){1'b0}}, less_than_unsigned};
            XOR:       result = op_a ^ op_b;
            OR:        result = op_a | op_b;
            AND:       result = op_a & op_b;
            SLL:       result = op_a << shamt;
            SRL:       result = op_a >> shamt;
            SRA:       result = $signed(op_a) >>> shamt;
            LUI:       result = op_b;
            AUIPC:     result = in_i.jump_imm_target;
            JAL, JALR: result = link;
            // ADD, loads and stores all want the plain sum
            default:   result = sum;
        endcase
    end

    assign alu_o.result             = result;
    assign alu_o.sum                = sum;
    assign alu_o.equal              = equal;
    assign alu_o.less_than          = less_than;
    assign alu_o.less_than_unsigned = less_than_unsigned;

endmodule

`default_nettype wire

/* hw/exec_branch.sv */
// Branch unit
// Decides taken branches and jumps and picks the context switch target
`timescale 1ns/1ps
`include "exec_settings.svh"

`default_nettype none

module exec_branch
    import exec_pkg::*;
(
    input  exec_in_t               in_i,
    input  alu_out_t               alu_i,
    input  trap_t                  trap_i,
    input  logic [`EXEC_XLEN-1:0]  mtvec_i,
    input  logic [`EXEC_XLEN-1:0]  mepc_i,
    output logic                   jump_o,
    output logic                   ctx_switch_o,
    output logic [`EXEC_XLEN-1:0]  ctx_switch_target_o
);

    logic                   should_jump;
    logic [`EXEC_XLEN-1:0]  jump_target;

    always_comb begin
        unique case (in_i.op)
            BEQ:       should_jump = alu_i.equal;
            BNE:       should_jump = !alu_i.equal;
            BLT:       should_jump = alu_i.less_than;
            BLTU:      should_jump = alu_i.less_than_unsigned;
            BGE:       should_jump = !alu_i.less_than;
            BGEU:      should_jump = !alu_i.less_than_unsigned;
            JAL, JALR: should_jump = 1'b1;
            default:   should_jump = 1'b0;
        endcase
    end

    // JALR drops bit 0 of rs1 + imm
    assign jump_target = (in_i.op == JALR) ? {alu_i.sum[`EXEC_XLEN-1:1], 1'b0}
                                           : in_i.jump_imm_target;

    assign jump_o = should_jump && !trap_i.raise_exception;

    always_comb begin
        if (trap_i.machine_return)
            ctx_switch_target_o = mepc_i;
        else if (trap_i.raise_exception || trap_i.interrupt_ack)
            ctx_switch_target_o = mtvec_i;
        else
            ctx_switch_target_o = jump_target;
    end

    assign ctx_switch_o = jump_o || trap_i.raise_exception
                       || trap_i.machine_return || trap_i.interrupt_ack;

endmodule

`default_nettype wire

/* hw/exec_lsu.sv */
// Load/store request former
// Aligned word address, byte lane enables and replicated store data
`timescale 1ns/1ps
`include "exec_settings.svh"

`default_nettype none

module exec_lsu
    import exec_pkg::*;
(
    input  exec_in_t  in_i,
    input  alu_out_t  alu_i,
    output mem_req_t  mem_o
);

    logic [3:0]             lane_we;
    logic [`EXEC_XLEN-1:0]  store_data;

    assign mem_o.address     = {alu_i.sum[`EXEC_XLEN-1:2], 2'b00};
    assign mem_o.read_enable = in_i.op inside {LB, LBU, LH, LHU, LW};

    // Lane enables from the byte offset
    always_comb begin
        unique case (in_i.op)
            SB: begin
                unique case (alu_i.sum[1:0])
                    2'b00: lane_we = 4'b0001;
                    2'b01: lane_we = 4'b0010;
                    2'b10: lane_we = 4'b0100;
                    2'b11: lane_we = 4'b1000;
                endcase
            end
            SH:      lane_we = alu_i.sum[1] ? 4'b1100 : 4'b0011;
            SW:      lane_we = 4'b1111;
            default: lane_we = 4'b0000;
        endcase
    end

    // Replicate so every lane sees the store value
    always_comb begin
        unique case (in_i.op)
            SB:      store_data = {4{in_i.rs2_data[7:0]}};
            SH:      store_data = {2{in_i.rs2_data[15:0]}};
            default: store_data = in_i.rs2_data;
        endcase
    end

    assign mem_o.write_enable = lane_we;
    assign mem_o.write_data   = store_data;

endmodule

`default_nettype wire

/* hw/exec_csr_priv.sv */
// CSR and privilege control
// Forms CSR requests, checks access rules and raises traps, MRET and interrupt ack
`timescale 1ns/1ps
`include "exec_settings.svh"

`default_nettype none

module exec_csr_priv
    import exec_pkg::*;
(
    input  exec_in_t  in_i,
    input  priv_e     privilege_i,
    input  logic      illegal_inst_i,
    input  logic      interrupt_pending_i,
    output csr_req_t  csr_o,
    output trap_t     trap_o
);

    logic        csr_read;
    logic        csr_write;
    logic        illegal_csr;
    logic        raise;
    logic        mret;
    logic [1:0]  addr_ro;
    logic [1:0]  addr_priv;

    ////////////////////////////////////////////////////////////////////////////
    // CSR request
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        unique case (in_i.op)
            CSRRW, CSRRWI: begin
                csr_read  = (in_i.rd != '0);
                csr_write = 1'b1;
            end
            CSRRS, CSRRC, CSRRSI, CSRRCI: begin
                csr_read  = 1'b1;
                csr_write = (in_i.rs1 != '0);
            end
            default: begin
                csr_read  = 1'b0;
                csr_write = 1'b0;
            end
        endcase
    end

    always_comb begin
        unique case (in_i.op)
            CSRRW, CSRRWI: csr_o.operation = WRITE;
            CSRRS, CSRRSI: csr_o.operation = SET;
            CSRRC, CSRRCI: csr_o.operation = CLEAR;
            default:       csr_o.operation = NONE;
        endcase
    end

    // Immediate forms carry the zero-extended rs1 field
    assign csr_o.data = (in_i.op inside {CSRRW, CSRRS, CSRRC})
                      ? in_i.rs1_data
                      : {{(`EXEC_XLEN-`EXEC_REG_W){1'b0}}, in_i.rs1};

    assign addr_ro   = in_i.csr_address[`EXEC_CSR_RO_MSB -: 2];
    assign addr_priv = in_i.csr_address[`EXEC_CSR_PRIV_MSB -: 2];

    assign illegal_csr = (csr_write && (addr_ro == 2'b11))
                      || ((csr_read || csr_write) && (addr_priv > privilege_i));

    assign csr_o.read_enable  = csr_read && !illegal_csr;
    assign csr_o.write_enable = csr_write && !illegal_csr;

    ////////////////////////////////////////////////////////////////////////////
    // Traps
    ////////////////////////////////////////////////////////////////////////////

    assign raise = (illegal_inst_i || illegal_csr || (in_i.op inside {ECALL, EBREAK}))
                && (in_i.op != NOP);

    assign mret = !raise && (in_i.op == MRET);

    always_comb begin
        if (!raise)
            trap_o.exception_code = NE;
        else if (illegal_inst_i || illegal_csr)
            trap_o.exception_code = ILLEGAL_INSTRUCTION;
        else if (in_i.op == ECALL)
            trap_o.exception_code = (privilege_i == USER) ? ECALL_FROM_UMODE
                                                          : ECALL_FROM_MMODE;
        else
            trap_o.exception_code = BREAKPOINT;
    end

    assign trap_o.raise_exception = raise;
    assign trap_o.machine_return  = mret;
    // Interrupts are taken only on a real instruction with no other trap
    assign trap_o.interrupt_ack   = interrupt_pending_i && (in_i.op != NOP) && !raise && !mret;

endmodule

`default_nettype wire

/* hw/exec_writeback.sv */
// Write-back register
// Selects the stage result and registers it for the next stage, held under stall
`timescale 1ns/1ps
`include "exec_settings.svh"

`default_nettype none

module exec_writeback
    import exec_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   stall,
    input  exec_in_t               in_i,
    input  alu_out_t               alu_i,
    input  trap_t                  trap_i,
    input  logic [`EXEC_XLEN-1:0]  csr_read_data_i,
    output wb_t                    wb_o
);

    logic [`EXEC_XLEN-1:0]  result;
    logic                   write_enable;

    always_comb begin
        unique case (in_i.op)
            CSRRW, CSRRS, CSRRC,
            CSRRWI, CSRRSI, CSRRCI: result = csr_read_data_i;
            default:                result = alu_i.result;
        endcase
    end

    // Stores and branches never write a register
    always_comb begin
        unique case (in_i.op)
            NOP,
            SB, SH, SW,
            BEQ, BNE, BLT, BLTU, BGE, BGEU: write_enable = 1'b0;
            default: write_enable = (in_i.rd != '0) && !trap_i.raise_exception;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wb_o.write_enable <= 1'b0;
            wb_o.op           <= NOP;
            wb_o.result       <= '0;
            wb_o.rd           <= '0;
        end
        else if (!stall) begin
            wb_o.write_enable <= write_enable;
            wb_o.op           <= in_i.op;
            wb_o.result       <= result;
            wb_o.rd           <= in_i.rd;
        end
    end

endmodule

`default_nettype wire

/* hw/exec_stage.sv */
// Execute stage top
// ALU, load/store, CSR/privilege, branch and write-back blocks side by side
`timescale 1ns/1ps
`include "exec_settings.svh"

`default_nettype none

module exec_stage
    import exec_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   stall_i,
    input  exec_in_t               in_i,
    input  priv_e                  privilege_i,
    input  logic                   illegal_inst_i,
    input  logic                   interrupt_pending_i,
    input  logic [`EXEC_XLEN-1:0]  mtvec_i,
    input  logic [`EXEC_XLEN-1:0]  mepc_i,
    input  logic [`EXEC_XLEN-1:0]  csr_read_data_i,
    output mem_req_t               mem_o,
    output csr_req_t               csr_o,
    output trap_t                  trap_o,
    output logic                   jump_o,
    output logic                   ctx_switch_o,
    output logic [`EXEC_XLEN-1:0]  ctx_switch_target_o,
    output wb_t                    wb_o
);

    alu_out_t  alu;

    exec_alu alu_i (
        .in_i  (in_i),
        .alu_o (alu)
    );

    exec_lsu lsu_i (
        .in_i  (in_i),
        .alu_i (alu),
        .mem_o (mem_o)
    );

    exec_csr_priv csr_priv_i (
        .in_i                (in_i),
        .privilege_i         (privilege_i),
        .illegal_inst_i      (illegal_inst_i),
        .interrupt_pending_i (interrupt_pending_i),
        .csr_o               (csr_o),
        .trap_o              (trap_o)
    );

    exec_branch branch_i (
        .in_i                (in_i),
        .alu_i               (alu),
        .trap_i              (trap_o),
        .mtvec_i             (mtvec_i),
        .mepc_i              (mepc_i),
        .jump_o              (jump_o),
        .ctx_switch_o        (ctx_switch_o),
        .ctx_switch_target_o (ctx_switch_target_o)
    );

    exec_writeback writeback_i (
        .clk             (clk),
        .reset_n         (reset_n),
        .stall           (stall_i),
        .in_i            (in_i),
        .alu_i           (alu),
        .trap_i          (trap_o),
        .csr_read_data_i (csr_read_data_i),
        .wb_o            (wb_o)
    );

endmodule

`default_nettype wire

/* verif/exec_props.sv */
// Execute stage properties
// Concurrent checks on the stage outputs, bound into the stage top
`timescale 1ns/1ps

`default_nettype none

module exec_props
    import exec_pkg::*;
(
    input logic      clk,
    input logic      reset_n,
    input logic      stall_i,
    input mem_req_t  mem_o,
    input trap_t     trap_o,
    input logic      ctx_switch_o,
    input wb_t       wb_o
);

    // Read by the testbench at the end of the run
    int failures = 0;

    mem_rw_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
        !(mem_o.read_enable && (mem_o.write_enable != 4'b0000)))
    else begin
        $error("Memory read and write enables active together");
        failures++;
    end

    exception_switches: assert property (@(posedge clk) disable iff (!reset_n)
        trap_o.raise_exception |-> ctx_switch_o)
    else begin
        $error("Exception raised without a context switch");
        failures++;
    end

    // First edge after reset release
    wb_reset_values: assert property (@(posedge clk)
        $rose(reset_n) |-> (!wb_o.write_enable && (wb_o.op == NOP)
                            && (wb_o.result == '0) && (wb_o.rd == '0)))
    else begin
        $error("Write-back register not at its reset value");
        failures++;
    end

    wb_held_in_stall: assert property (@(posedge clk) disable iff (!reset_n)
        stall_i |=> $stable(wb_o))
    else begin
        $error("Write-back register changed while stalled");
        failures++;
    end

endmodule

bind exec_stage exec_props props_i (
    .clk          (clk),
    .reset_n      (reset_n),
    .stall_i      (stall_i),
    .mem_o        (mem_o),
    .trap_o       (trap_o),
    .ctx_switch_o (ctx_switch_o),
    .wb_o         (wb_o)
);

`default_nettype wire

/* verif/exec_tb.sv */
// Execute stage testbench
// LFSR operands and directed cases, checked against models of the stage rules
`timescale 1ns/1ps
`include "exec_settings.svh"

`default_nettype none

module exec_tb
    import exec_pkg::*;
();

    localparam int NUM_TESTS   = 6;
    localparam int CYCLE_LIMIT = 40 * NUM_TESTS + 20;

    logic                   clk;
    logic                   reset_n;
    logic                   stall;
    exec_in_t               instr;
    priv_e                  privilege;
    logic                   illegal_inst;
    logic                   irq_pending;
    logic [`EXEC_XLEN-1:0]  mtvec;
    logic [`EXEC_XLEN-1:0]  mepc;
    logic [`EXEC_XLEN-1:0]  csr_rdata;
    mem_req_t               mem;
    csr_req_t               csr;
    trap_t                  trap;
    logic                   jump;
    logic                   ctx_switch;
    logic [`EXEC_XLEN-1:0]  ctx_target;
    wb_t                    wb;

    logic [31:0]  lfsr;
    int           errors = 0;
    int           test_errors = 0;
    int           checks = 0;
    int           tests = 0;
    int           cycles = 0;
    string        test_name;

    exec_op_e alu_ops[12] = '{ADD, SUB, SLT, SLTU, XOR, OR, AND, SLL, SRL, SRA, LUI, AUIPC};
    exec_op_e br_ops[6]   = '{BEQ, BNE, BLT, BLTU, BGE, BGEU};
    exec_op_e mem_ops[6]  = '{LB, LHU, LW, SB, SH, SW};

    exec_stage dut_i (
        .clk                 (clk),
        .reset_n             (reset_n),
        .stall_i             (stall),
        .in_i                (instr),
        .privilege_i         (privilege),
        .illegal_inst_i      (illegal_inst),
        .interrupt_pending_i (irq_pending),
        .mtvec_i             (mtvec),
        .mepc_i              (mepc),
        .csr_read_data_i     (csr_rdata),
        .mem_o               (mem),
        .csr_o               (csr),
        .trap_o              (trap),
        .jump_o              (jump),
        .ctx_switch_o        (ctx_switch),
        .ctx_switch_target_o (ctx_target),
        .wb_o                (wb)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic exec_in_t make(input exec_op_e op, input logic [31:0] a,
                                      input logic [31:0] b, input logic [4:0] rd);
        exec_in_t v;
        v = '0;
        v.op = op;
        v.rs1_data = a;
        v.second_operand = b;
        v.rd = rd;
        v.rs1 = 5'd1;
        v.rs2_data = rand_bits(32);
        v.pc = {rand_bits(30), 2'b00};
        v.jump_imm_target = rand_bits(32);
        return v;
    endfunction

    function automatic logic [31:0] alu_model(input exec_in_t v);
        logic [31:0] a;
        logic [31:0] b;
        a = v.rs1_data;
        b = v.second_operand;
        case (v.op)
            SUB:   return a - b;
            SLT:   return {31'b0, $signed(a) < $signed(b)};
            SLTU:  return {31'b0, a < b};
            XOR:   return a ^ b;
            OR:    return a | b;
            AND:   return a & b;
            SLL:   return a << b[4:0];
            SRL:   return a >> b[4:0];
            SRA:   return $signed(a) >>> b[4:0];
            LUI:   return b;
            AUIPC: return v.jump_imm_target;
            default: return a + b;
        endcase
    endfunction

    function automatic logic taken(input exec_in_t v);
        case (v.op)
            BEQ:  return v.rs1_data == v.second_operand;
            BNE:  return v.rs1_data != v.second_operand;
            BLT:  return $signed(v.rs1_data) < $signed(v.second_operand);
            BLTU: return v.rs1_data < v.second_operand;
            BGE:  return $signed(v.rs1_data) >= $signed(v.second_operand);
            BGEU: return v.rs1_data >= v.second_operand;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [3:0] lane_model(input exec_op_e op, input logic [1:0] off);
        case (op)
            SB: return 4'b0001 << off;
            SH: return off[1] ? 4'b1100 : 4'b0011;
            SW: return 4'b1111;
            default: return 4'b0000;
        endcase
    endfunction

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("[FAIL] %s: %s expected %h actual %h", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = 0;
        tests++;
    endtask

    task automatic finish_test();
        errors += test_errors;
        $display("Test %-10s %s", test_name, (test_errors == 0) ? "ok" : "FAILED");
    endtask

    // Drives everything on the falling edge, then lets the logic settle
    task automatic apply(input exec_in_t v, input priv_e p, input logic ill,
                         input logic irq, input logic st);
        @(negedge clk);
        instr = v;
        privilege = p;
        illegal_inst = ill;
        irq_pending = irq;
        stall = st;
        #1;
    endtask

    task automatic run(input exec_in_t v);
        apply(v, MACHINE, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic csr_case(input exec_op_e op, input logic [4:0] rd, input logic [4:0] rs1,
                            input logic [11:0] addr, input priv_e p);
        exec_in_t v;
        logic     wr_en;
        logic     rd_en;
        logic     bad;
        logic     is_write;
        is_write = op inside {CSRRW, CSRRWI};
        v = make(op, rand_bits(32), 32'd0, rd);
        v.rs1 = rs1;
        v.csr_address = addr;
        wr_en = is_write || (rs1 != 5'd0);
        rd_en = !is_write || (rd != 5'd0);
        bad = (wr_en && (addr[11:10] == 2'b11)) || (addr[9:8] > p);
        apply(v, p, 1'b0, 1'b0, 1'b0);
        check("csr read", rd_en && !bad, csr.read_enable);
        check("csr write", wr_en && !bad, csr.write_enable);
        check("csr op", is_write ? WRITE : (op inside {CSRRS, CSRRSI}) ? SET : CLEAR,
              csr.operation);
        check("csr data", (op inside {CSRRW, CSRRS, CSRRC}) ? v.rs1_data : {27'd0, rs1},
              csr.data);
        check("exception", bad, trap.raise_exception);
        check("cause", bad ? ILLEGAL_INSTRUCTION : NE, trap.exception_code);
        @(negedge clk);
        check("wb enable", !bad && (rd != 5'd0), wb.write_enable);
        if (!bad && (rd != 5'd0))
            check("wb result", csr_rdata, wb.result);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        exec_in_t     v;
        logic [31:0]  a;
        logic [31:0]  exp;
        lfsr = 32'hbcf2_8deb;
        reset_n = 1'b0;
        stall = 1'b0;
        instr = '0;
        privilege = MACHINE;
        illegal_inst = 1'b0;
        irq_pending = 1'b0;
        mtvec = rand_bits(32);
        mepc = rand_bits(32);
        csr_rdata = rand_bits(32);
        repeat (4) @(negedge clk);
        reset_n = 1'b1;

        start_test("alu");
        foreach (alu_ops[i]) begin
            v = make(alu_ops[i], rand_bits(32), rand_bits(32), rand_bits(5));
            // Every fourth op targets x0
            if (i % 4 == 0)
                v.rd = 5'd0;
            run(v);
            @(negedge clk);
            check("result", alu_model(v), wb.result);
            check("write enable", v.rd != 5'd0, wb.write_enable);
            check("op", v.op, wb.op);
        end
        finish_test();

        start_test("branch");
        foreach (br_ops[i]) begin
            for (int k = 0; k < 2; k++) begin
                a = rand_bits(32);
                v = make(br_ops[i], a, (k == 0) ? a : rand_bits(32), 5'd0);
                run(v);
                check("jump", taken(v), jump);
                check("ctx switch", taken(v), ctx_switch);
                if (taken(v))
                    check("target", v.jump_imm_target, ctx_target);
            end
        end
        for (int k = 0; k < 4; k++) begin
            v = make((k < 2) ? JAL : JALR, rand_bits(32), rand_bits(32), 5'd1);
            v.compressed = k[0];
            exp = (v.op == JALR) ? ((v.rs1_data + v.second_operand) & ~32'd1)
                                 : v.jump_imm_target;
            run(v);
            check("jump", 1'b1, jump);
            check("target", exp, ctx_target);
            @(negedge clk);
            check("link", v.pc + (v.compressed ? 32'd2 : 32'd4), wb.result);
        end
        finish_test();

        start_test("load/store");
        for (int off = 0; off < 4; off++) begin
            foreach (mem_ops[i]) begin
                v = make(mem_ops[i], rand_bits(32) & ~32'd3, off, 5'd2);
                run(v);
                check("address", (v.rs1_data + off) & ~32'd3, mem.address);
                check("read enable", v.op inside {LB, LBU, LH, LHU, LW}, mem.read_enable);
                check("lanes", lane_model(v.op, off[1:0]), mem.write_enable);
                if (v.op == SB)
                    check("data", {4{v.rs2_data[7:0]}}, mem.write_data);
                if (v.op == SH)
                    check("data", {2{v.rs2_data[15:0]}}, mem.write_data);
                if (v.op == SW)
                    check("data", v.rs2_data, mem.write_data);
            end
        end
        finish_test();

        start_test("csr");
        csr_case(CSRRW, 5'd0, 5'd5, 12'h300, MACHINE);
        csr_case(CSRRW, 5'd3, 5'd5, 12'h340, MACHINE);
        csr_case(CSRRS, 5'd4, 5'd0, 12'h300, MACHINE);
        csr_case(CSRRCI, 5'd6, 5'd7, 12'h341, MACHINE);
        // Write to a read-only counter
        csr_case(CSRRSI, 5'd8, 5'd9, 12'hc00, MACHINE);
        csr_case(CSRRS, 5'd8, 5'd0, 12'hc00, USER);
        // Machine CSR from user mode
        csr_case(CSRRS, 5'd9, 5'd0, 12'h300, USER);
        csr_case(CSRRWI, 5'd10, 5'd3, 12'h000, USER);
        finish_test();

        start_test("traps");
        v = make(ECALL, 32'd0, 32'd0, 5'd0);
        apply(v, USER, 1'b0, 1'b0, 1'b0);
        check("cause", ECALL_FROM_UMODE, trap.exception_code);
        check("target", mtvec, ctx_target);
        apply(v, MACHINE, 1'b0, 1'b0, 1'b0);
        check("cause", ECALL_FROM_MMODE, trap.exception_code);
        check("target", mtvec, ctx_target);
        v.op = EBREAK;
        run(v);
        check("cause", BREAKPOINT, trap.exception_code);
        check("ctx switch", 1'b1, ctx_switch);
        v.op = MRET;
        run(v);
        check("mret", 1'b1, trap.machine_return);
        check("exception", 1'b0, trap.raise_exception);
        check("target", mepc, ctx_target);
        v = make(ADD, rand_bits(32), rand_bits(32), 5'd3);
        apply(v, MACHINE, 1'b0, 1'b1, 1'b0);
        check("irq ack", 1'b1, trap.interrupt_ack);
        check("target", mtvec, ctx_target);
        // Illegal JAL must not jump or write the link
        v.op = JAL;
        apply(v, MACHINE, 1'b1, 1'b0, 1'b0);
        check("cause", ILLEGAL_INSTRUCTION, trap.exception_code);
        check("jump", 1'b0, jump);
        check("target", mtvec, ctx_target);
        @(negedge clk);
        check("wb enable", 1'b0, wb.write_enable);
        v.op = NOP;
        apply(v, MACHINE, 1'b1, 1'b1, 1'b0);
        check("exception", 1'b0, trap.raise_exception);
        check("irq ack", 1'b0, trap.interrupt_ack);
        check("ctx switch", 1'b0, ctx_switch);
        finish_test();

        start_test("stall");
        v = make(XOR, rand_bits(32), rand_bits(32), 5'd7);
        exp = alu_model(v);
        run(v);
        @(negedge clk);
        check("result", exp, wb.result);
        for (int k = 0; k < 4; k++) begin
            apply(make(OR, rand_bits(32), rand_bits(32), 5'd9), MACHINE, 1'b0, 1'b0, 1'b1);
            check("held result", exp, wb.result);
            check("held rd", 32'd7, wb.rd);
        end
        v = make(SUB, rand_bits(32), rand_bits(32), 5'd11);
        run(v);
        check("held result", exp, wb.result);
        @(negedge clk);
        check("new result", alu_model(v), wb.result);
        check("new rd", 32'd11, wb.rd);
        finish_test();

        errors += dut_i.props_i.failures;
        $display("Tests: %0d  checks: %0d  property failures: %0d  errors: %0d",
                 tests, checks, dut_i.props_i.failures, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+hw
hw/exec_pkg.sv
hw/exec_alu.sv
hw/exec_branch.sv
hw/exec_lsu.sv
hw/exec_csr_priv.sv
hw/exec_writeback.sv
hw/exec_stage.sv
verif/exec_props.sv
verif/exec_tb.sv

/* Bender.yml */
package:
  name: exec_stage

sources:
  - include_dirs:
      - hw
    files:
      - hw/exec_pkg.sv
      - hw/exec_alu.sv
      - hw/exec_branch.sv
      - hw/exec_lsu.sv
      - hw/exec_csr_priv.sv
      - hw/exec_writeback.sv
      - hw/exec_stage.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/exec_props.sv
      - verif/exec_tb.sv
